//--- ipu.f
src/ipu_pkg.sv
src/ipu_distributor.sv
src/ipu_simd_lane.sv
src/ipu_collector.sv
src/ipu_top.sv
verification/tb_ipu.sv

//--- Makefile
# Verilator build and run of the SIMD IPU testbench

VERILATOR ?= verilator
TOP       ?= tb_ipu
FILELIST  ?= ipu.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

SRCS     := $(wildcard src/*.sv) $(wildcard verification/*.sv)
BIN      := $(OBJ_DIR)/V$(TOP)
PASS_MSG := PASS: all tests

.PHONY: all build run clean

all: run

build: $(BIN)

# Rebuilt only when a source or the file list changes
$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	$(BIN) | tee $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) || { echo "Simulation failed, see $(LOG)"; exit 1; }
	@echo "Simulation passed"

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- verification/tb_ipu.sv
////////////////////////////////////////////////////////////
// Testbench for ipu_top with an element-wise reference model
// Concurrent assertions do the checking; needs assertions on
////////////////////////////////////////////////////////////

`timescale 1ns/100ps

module tb_ipu;

    localparam int N_SEW32     = 200;
    localparam int N_SEW16     = 200;
    localparam int N_SEW8      = 200;
    localparam int N_STALL     = 100;
    localparam int N_MIXED     = 50;
    localparam int TOTAL_TXN   = N_SEW32 + N_SEW16 + N_SEW8 + N_STALL + N_MIXED;
    localparam int CYCLE_LIMIT = 2 * TOTAL_TXN + 100;
    localparam int DRAIN_LIMIT = 64;

    logic           clk_i;
    logic           rst_n_i;
    ipu_pkg::op_e   operation_i;
    logic           operation_valid_i;
    logic           operation_ready_o;
    ipu_pkg::word_t op_s1_i;
    ipu_pkg::word_t op_s2_i;
    ipu_pkg::sew_e  sew_i;
    ipu_pkg::word_t result_o;
    ipu_pkg::strb_t result_valid_o;
    logic           result_ready_i;

    // Expected results, oldest first
    ipu_pkg::word_t exp_word [$];
    ipu_pkg::strb_t exp_strb [$];
    ipu_pkg::word_t head_word;
    ipu_pkg::strb_t head_strb;
    logic           have_head = 1'b0;

    logic           prev_rst = 1'b0;
    logic           prev_stall = 1'b0;
    ipu_pkg::word_t prev_word;
    ipu_pkg::strb_t prev_strb;
    logic           stalled;
    logic           rand_ready;

    int taken_count = 0;
    int cycle_count = 0;
    int chk_errs = 0;
    int proc_errs = 0;
    int tests_run = 0;
    int tests_failed = 0;

    initial begin : clock_gen
        clk_i = 1'b0;
        forever #4 clk_i = ~clk_i;
    end

    ipu_top DUT (
        .clk_i             (clk_i),
        .rst_n_i           (rst_n_i),
        .operation_i       (operation_i),
        .operation_valid_i (operation_valid_i),
        .operation_ready_o (operation_ready_o),
        .op_s1_i           (op_s1_i),
        .op_s2_i           (op_s2_i),
        .sew_i             (sew_i),
        .result_o          (result_o),
        .result_valid_o    (result_valid_o),
        .result_ready_i    (result_ready_i)
    );

    assign stalled = (|result_valid_o) & ~result_ready_i;

    ////////////////////////////////////////////////////////////
    // Reference model
    ////////////////////////////////////////////////////////////

    function automatic void reference_result(input ipu_pkg::op_e op, input ipu_pkg::sew_e sew,
                                             input ipu_pkg::word_t a, input ipu_pkg::word_t b,
                                             output ipu_pkg::word_t w, output ipu_pkg::strb_t s);
        int unsigned ew;
        longint      mask;
        longint      ea;
        longint      eb;
        longint      r;
        ew   = (sew == ipu_pkg::SEW_8) ? 8 : (sew == ipu_pkg::SEW_16) ? 16 : 32;
        mask = (longint'(1) << ew) - 1;
        w    = '0;
        s    = '0;
        for (int unsigned k = 0; k < 32 / ew; k++) begin
            ea = (longint'(a) >> (ew * k)) & mask;
            eb = (longint'(b) >> (ew * k)) & mask;
            // Two's complement view of each element for signed compare
            if (op == ipu_pkg::VMIN || op == ipu_pkg::VMAX) begin
                if (((ea >> (ew - 1)) & 1) != 0) ea = ea - (longint'(1) << ew);
                if (((eb >> (ew - 1)) & 1) != 0) eb = eb - (longint'(1) << ew);
            end
            case (op)
                ipu_pkg::VADD:  r = ea + eb;
                ipu_pkg::VSUB:  r = ea - eb;
                ipu_pkg::VRSUB: r = eb - ea;
                ipu_pkg::VAND:  r = ea & eb;
                ipu_pkg::VOR:   r = ea | eb;
                ipu_pkg::VXOR:  r = ea ^ eb;
                ipu_pkg::VMIN,
                ipu_pkg::VMINU: r = (ea < eb) ? ea : eb;
                default:        r = (ea < eb) ? eb : ea;
            endcase
            w = w | ipu_pkg::word_t'((r & mask) << (ew * k));
            s = s | ipu_pkg::strb_t'(((1 << (ew / 8)) - 1) << (k * ew / 8));
        end
    endfunction

    ////////////////////////////////////////////////////////////
    // Scoreboard and watchdog
    ////////////////////////////////////////////////////////////

    always @(posedge clk_i) begin : scoreboard
        ipu_pkg::word_t w;
        ipu_pkg::strb_t s;
        if (!rst_n_i) begin
            exp_word.delete();
            exp_strb.delete();
        end else begin
            if ((|result_valid_o) && result_ready_i && exp_word.size() > 0) begin
                void'(exp_word.pop_front());
                void'(exp_strb.pop_front());
                taken_count = taken_count + 1;
            end
            if (operation_valid_i && operation_ready_o) begin
                reference_result(operation_i, sew_i, op_s1_i, op_s2_i, w, s);
                exp_word.push_back(w);
                exp_strb.push_back(s);
            end
        end
        have_head  <= (exp_word.size() > 0);
        head_word  <= (exp_word.size() > 0) ? exp_word[0] : '0;
        head_strb  <= (exp_strb.size() > 0) ? exp_strb[0] : '0;
        prev_rst   <= rst_n_i;
        prev_stall <= stalled;
        prev_word  <= result_o;
        prev_strb  <= result_valid_o;
    end

    always @(posedge clk_i) begin : watchdog
        cycle_count = cycle_count + 1;
        if (cycle_count >= CYCLE_LIMIT) begin
            $display("Run stopped after %0d cycles, the DUT stopped responding", cycle_count);
            $display("FAIL: see errors above");
            $finish;
        end
    end

    ////////////////////////////////////////////////////////////
    // Assertions
    ////////////////////////////////////////////////////////////

    a_reset_valid: assert property (@(posedge clk_i) !prev_rst |-> result_valid_o == '0)
        else begin
            $display("ERROR result_valid_o: expected 0, got %h", $sampled(result_valid_o));
            chk_errs++;
        end

    a_reset_ready: assert property (@(posedge clk_i) !prev_rst |-> operation_ready_o)
        else begin
            $display("ERROR operation_ready_o: expected 1, got %h", $sampled(operation_ready_o));
            chk_errs++;
        end

    a_word: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        ((|result_valid_o) && result_ready_i) |-> result_o == head_word)
        else begin
            $display("ERROR result_o: expected %h, got %h", $sampled(head_word),
                     $sampled(result_o));
            chk_errs++;
        end

    a_strb: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        ((|result_valid_o) && result_ready_i) |-> result_valid_o == head_strb)
        else begin
            $display("ERROR result_valid_o: expected %h, got %h", $sampled(head_strb),
                     $sampled(result_valid_o));
            chk_errs++;
        end

    a_extra: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        ((|result_valid_o) && result_ready_i) |-> have_head)
        else begin
            $display("A result was delivered with no transaction outstanding");
            chk_errs++;
        end

    a_latency: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        (operation_valid_i && operation_ready_o) |=> (|result_valid_o))
        else begin
            $display("No result appeared one cycle after an accepted transaction");
            chk_errs++;
        end

    a_hold_word: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        prev_stall |-> result_o == prev_word)
        else begin
            $display("ERROR result_o: held %h, changed to %h", $sampled(prev_word),
                     $sampled(result_o));
            chk_errs++;
        end

    a_hold_strb: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        prev_stall |-> result_valid_o == prev_strb)
        else begin
            $display("ERROR result_valid_o: held %h, changed to %h", $sampled(prev_strb),
                     $sampled(result_valid_o));
            chk_errs++;
        end

    a_stall_ready: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        stalled |-> !operation_ready_o)
        else begin
            $display("ERROR operation_ready_o: expected 0, got %h", $sampled(operation_ready_o));
            chk_errs++;
        end

    ////////////////////////////////////////////////////////////
    // Stimulus
    ////////////////////////////////////////////////////////////

    function automatic int error_total();
        return chk_errs + proc_errs;
    endfunction

    // Advance to just after the next rising edge
    task automatic next_cycle();
        @(posedge clk_i);
        #1;
        if (rand_ready) result_ready_i = 1'($urandom % 2);
    endtask

    task automatic issue_op(ipu_pkg::op_e op, ipu_pkg::sew_e sew, ipu_pkg::word_t a,
                            ipu_pkg::word_t b);
        logic got;
        operation_i       = op;
        sew_i             = sew;
        op_s1_i           = a;
        op_s2_i           = b;
        operation_valid_i = 1'b1;
        do begin
            @(negedge clk_i);
            got = operation_ready_o;
            next_cycle();
        end while (!got);
        operation_valid_i = 1'b0;
    endtask

    // Outstanding results get a bounded number of cycles to arrive
    task automatic wait_drained();
        int waited;
        waited            = 0;
        operation_valid_i = 1'b0;
        while (exp_word.size() != 0 && waited < DRAIN_LIMIT) begin
            next_cycle();
            waited++;
        end
    endtask

    // sew_sel 0, 1, 2 pick SEW_32, SEW_16, SEW_8; anything else mixes them
    task automatic run_random_ops(int n, int sew_sel, bit top_bits, bit gaps);
        ipu_pkg::op_e   op;
        ipu_pkg::sew_e  sew;
        ipu_pkg::word_t a;
        ipu_pkg::word_t b;
        for (int i = 0; i < n; i++) begin
            op = ipu_pkg::op_e'(4'($urandom % 10));
            case (sew_sel)
                0:       sew = ipu_pkg::SEW_32;
                1:       sew = ipu_pkg::SEW_16;
                2:       sew = ipu_pkg::SEW_8;
                default: sew = ipu_pkg::sew_e'(2'($urandom % 3));
            endcase
            a = $urandom;
            b = $urandom;
            if (top_bits && ($urandom % 2) == 1) a = a | 32'h8080_8080;
            if (top_bits && ($urandom % 2) == 1) b = b | 32'h8080_8080;
            if (gaps && ($urandom % 4) == 0) next_cycle();
            issue_op(op, sew, a, b);
        end
    endtask

    task automatic report_test(int num, string name, int first_err);
        int n;
        n = error_total() - first_err;
        tests_run++;
        if (n == 0) begin
            $display("Test %0d %s: ok", num, name);
        end else begin
            tests_failed++;
            $display("Test %0d %s: %0d errors", num, name, n);
        end
    endtask

    initial begin : stimulus
        int first;
        int start_taken;
        int start_cycle;
        void'($urandom(24449));
        rst_n_i           = 1'b0;
        operation_i       = ipu_pkg::VADD;
        operation_valid_i = 1'b0;
        op_s1_i           = '0;
        op_s2_i           = '0;
        sew_i             = ipu_pkg::SEW_32;
        result_ready_i    = 1'b1;
        rand_ready        = 1'b0;
        repeat (5) @(posedge clk_i);
        #1;
        rst_n_i = 1'b1;

        first = error_total();
        next_cycle();
        next_cycle();
        report_test(1, "reset state", first);

        first = error_total();
        run_random_ops(N_SEW32, 0, 1'b1, 1'b0);
        wait_drained();
        report_test(2, "random SEW_32", first);

        first = error_total();
        run_random_ops(N_SEW16, 1, 1'b1, 1'b0);
        run_random_ops(N_SEW8, 2, 1'b1, 1'b0);
        wait_drained();
        report_test(3, "random SEW_16 and SEW_8", first);

        // Random back-pressure from the result side
        first = error_total();
        rand_ready = 1'b1;
        run_random_ops(N_STALL, 3, 1'b1, 1'b1);
        wait_drained();
        rand_ready     = 1'b0;
        result_ready_i = 1'b1;
        next_cycle();
        report_test(4, "random back-pressure", first);

        first       = error_total();
        start_taken = taken_count;
        start_cycle = cycle_count;
        run_random_ops(N_MIXED, 3, 1'b1, 1'b0);
        next_cycle();
        assert (taken_count - start_taken == N_MIXED && cycle_count - start_cycle == N_MIXED + 1)
            else begin
                $display("Back-to-back run gave %0d results in %0d cycles, not one per cycle",
                         taken_count - start_taken, cycle_count - start_cycle);
                proc_errs++;
            end
        wait_drained();
        report_test(5, "back-to-back mixed SEW", first);

        assert (exp_word.size() == 0)
            else begin
                $display("%0d expected results were never delivered", exp_word.size());
                proc_errs++;
            end

        $display("Summary: %0d tests, %0d failed, %0d check errors", tests_run, tests_failed,
                 error_total());
        if (error_total() == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

//--- src/ipu_top.sv
////////////////////////////////////////////////////////////
// 32-bit SIMD integer unit, SEW of 8, 16 or 32 bits
// Result one cycle after acceptance; one item in flight
// Inputs must stay stable while valid is high and ready low
////////////////////////////////////////////////////////////

`timescale 1ns/100ps

module ipu_top (
    input  logic           clk_i,
    input  logic           rst_n_i,
    input  ipu_pkg::op_e   operation_i,
    input  logic           operation_valid_i,
    output logic           operation_ready_o,
    input  ipu_pkg::word_t op_s1_i,
    input  ipu_pkg::word_t op_s2_i,
    input  ipu_pkg::sew_e  sew_i,
    output ipu_pkg::word_t result_o,
    output ipu_pkg::strb_t result_valid_o,
    input  logic           result_ready_i
);

    logic [ipu_pkg::NUM_LANES-1:0]           lane_valid;
    logic [ipu_pkg::NUM_LANES-1:0]           lane_ready;
    ipu_pkg::word_t [ipu_pkg::NUM_LANES-1:0] lane_op_a;
    ipu_pkg::word_t [ipu_pkg::NUM_LANES-1:0] lane_op_b;
    logic                                    lane_signed;
    ipu_pkg::word_t [ipu_pkg::NUM_LANES-1:0] lane_result;
    logic [ipu_pkg::NUM_LANES-1:0]           lane_result_valid;

    ////////////////////////////////////////////////////////////
    // Distributor
    ////////////////////////////////////////////////////////////

    ipu_distributor i_distributor (
        .operation_i       (operation_i),
        .operation_valid_i (operation_valid_i),
        .op_s1_i           (op_s1_i),
        .op_s2_i           (op_s2_i),
        .sew_i             (sew_i),
        .lane_ready_i      (lane_ready),
        .operation_ready_o (operation_ready_o),
        .lane_valid_o      (lane_valid),
        .lane_op_a_o       (lane_op_a),
        .lane_op_b_o       (lane_op_b),
        .lane_signed_o     (lane_signed)
    );

    ////////////////////////////////////////////////////////////
    // Lanes
    ////////////////////////////////////////////////////////////

    for (genvar i = 0; i < ipu_pkg::NUM_LANES; i++) begin : gen_lane
        logic [ipu_pkg::LANE_WIDTH[i]-1:0] lane_res;

        ipu_simd_lane #(
            .Width (ipu_pkg::LANE_WIDTH[i])
        ) i_lane (
            .clk_i          (clk_i),
            .rst_n_i        (rst_n_i),
            .operation_i    (operation_i),
            .valid_i        (lane_valid[i]),
            .ready_o        (lane_ready[i]),
            .op_a_i         (lane_op_a[i][ipu_pkg::LANE_WIDTH[i]-1:0]),
            .op_b_i         (lane_op_b[i][ipu_pkg::LANE_WIDTH[i]-1:0]),
            .signed_i       (lane_signed),
            .result_o       (lane_res),
            .result_valid_o (lane_result_valid[i]),
            .result_ready_i (result_ready_i)
        );

        // Zero-extended to a word for the collector
        assign lane_result[i] = ipu_pkg::word_t'(lane_res);
    end

    ////////////////////////////////////////////////////////////
    // Collector
    ////////////////////////////////////////////////////////////

    ipu_collector i_collector (
        .lane_result_i       (lane_result),
        .lane_result_valid_i (lane_result_valid),
        .result_o            (result_o),
        .result_valid_o      (result_valid_o)
    );

endmodule

//--- src/ipu_collector.sv
////////////////////////////////////////////////////////////
// Packs lane results into one word with byte strobes
// SEW is recovered from the lane valid pattern
// Any other pattern gives zero strobes
////////////////////////////////////////////////////////////

`timescale 1ns/100ps

module ipu_collector (
    input  ipu_pkg::word_t [ipu_pkg::NUM_LANES-1:0] lane_result_i,
    input  logic [ipu_pkg::NUM_LANES-1:0]           lane_result_valid_i,
    output ipu_pkg::word_t                          result_o,
    output ipu_pkg::strb_t                          result_valid_o
);

    logic          pattern_ok;
    ipu_pkg::sew_e held_sew;

    always_comb begin : sew_infer
        pattern_ok = 1'b1;
        held_sew   = ipu_pkg::SEW_32;
        case (lane_result_valid_i)
            4'b1111: held_sew = ipu_pkg::SEW_8;
            4'b1100: held_sew = ipu_pkg::SEW_16;
            4'b1000: held_sew = ipu_pkg::SEW_32;
            default: pattern_ok = 1'b0;
        endcase
    end

    always_comb begin : pack
        result_o       = lane_result_i[ipu_pkg::WIDE_LANE];
        result_valid_o = '0;
        if (pattern_ok) begin
            unique case (held_sew)
                ipu_pkg::SEW_8: begin
                    for (int i = 0; i < ipu_pkg::NUM_LANES; i++) begin
                        result_o[8*i +: 8]   = lane_result_i[i][7:0];
                        result_valid_o[i]    = lane_result_valid_i[i];
                    end
                end
                ipu_pkg::SEW_16: begin
                    result_o       = {lane_result_i[3][15:0], lane_result_i[2][15:0]};
                    result_valid_o = {{2{lane_result_valid_i[3]}},
                                      {2{lane_result_valid_i[2]}}};
                end
                default: begin
                    result_o       = lane_result_i[ipu_pkg::WIDE_LANE];
                    result_valid_o = {ipu_pkg::STRB_W{lane_result_valid_i[ipu_pkg::WIDE_LANE]}};
                end
            endcase
        end
    end

endmodule

//--- src/ipu_simd_lane.sv
////////////////////////////////////////////////////////////
// One SIMD lane: ALU at Width bits and a result register
// Operands arrive already extended to the lane width
// Loads whenever ready; result held while downstream stalls
////////////////////////////////////////////////////////////

`timescale 1ns/100ps

module ipu_simd_lane #(
    parameter int unsigned Width = 32
) (
    input  logic             clk_i,
    input  logic             rst_n_i,
    input  ipu_pkg::op_e     operation_i,
    input  logic             valid_i,
    output logic             ready_o,
    input  logic [Width-1:0] op_a_i,
    input  logic [Width-1:0] op_b_i,
    input  logic             signed_i,
    output logic [Width-1:0] result_o,
    output logic             result_valid_o,
    input  logic             result_ready_i
);

    logic [Width-1:0] alu_res;
    logic [Width-1:0] result_q;
    logic             valid_q;
    logic             a_lt_b;

    ////////////////////////////////////////////////////////////
    // ALU
    ////////////////////////////////////////////////////////////

    // One comparator shared by the four min/max forms
    assign a_lt_b = signed_i ? ($signed(op_a_i) < $signed(op_b_i)) : (op_a_i < op_b_i);

    always_comb begin : alu
        unique case (operation_i)
            ipu_pkg::VADD:  alu_res = op_a_i + op_b_i;
            ipu_pkg::VSUB:  alu_res = op_a_i - op_b_i;
            ipu_pkg::VRSUB: alu_res = op_b_i - op_a_i;
            ipu_pkg::VAND:  alu_res = op_a_i & op_b_i;
            ipu_pkg::VOR:   alu_res = op_a_i | op_b_i;
            ipu_pkg::VXOR:  alu_res = op_a_i ^ op_b_i;
            ipu_pkg::VMIN,
            ipu_pkg::VMINU: alu_res = a_lt_b ? op_a_i : op_b_i;
            ipu_pkg::VMAX,
            ipu_pkg::VMAXU: alu_res = a_lt_b ? op_b_i : op_a_i;
            default:        alu_res = '0;
        endcase
    end

    ////////////////////////////////////////////////////////////
    // Result register
    ////////////////////////////////////////////////////////////

    // Free when empty or when the held result leaves this cycle
    assign ready_o = ~valid_q | result_ready_i;

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            valid_q <= 1'b0;
        end else if (ready_o) begin
            valid_q <= valid_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (ready_o) begin
            result_q <= alu_res;
        end
    end

    assign result_o       = result_q;
    assign result_valid_o = valid_q;

endmodule

//--- src/ipu_distributor.sv
////////////////////////////////////////////////////////////
// Spreads one operand pair over the four lanes by SEW
// Purely combinational; ready follows the 32-bit lane
// SEW encoding 3 is treated as SEW_32
////////////////////////////////////////////////////////////

`timescale 1ns/100ps

module ipu_distributor (
    input  ipu_pkg::op_e                           operation_i,
    input  logic                                   operation_valid_i,
    input  ipu_pkg::word_t                         op_s1_i,
    input  ipu_pkg::word_t                         op_s2_i,
    input  ipu_pkg::sew_e                          sew_i,
    input  logic [ipu_pkg::NUM_LANES-1:0]          lane_ready_i,
    output logic                                   operation_ready_o,
    output logic [ipu_pkg::NUM_LANES-1:0]          lane_valid_o,
    output ipu_pkg::word_t [ipu_pkg::NUM_LANES-1:0] lane_op_a_o,
    output ipu_pkg::word_t [ipu_pkg::NUM_LANES-1:0] lane_op_b_o,
    output logic                                   lane_signed_o
);

    logic                          is_signed;
    logic                          accept;
    logic [ipu_pkg::NUM_LANES-1:0] lane_active;

    // Extend the element in the low bits up to a full word
    function automatic ipu_pkg::word_t extend(ipu_pkg::word_t elem, ipu_pkg::sew_e sew,
                                              logic sgn);
        ipu_pkg::word_t res;
        case (sew)
            ipu_pkg::SEW_8:  res = sgn ? {{24{elem[7]}}, elem[7:0]} : {24'd0, elem[7:0]};
            ipu_pkg::SEW_16: res = sgn ? {{16{elem[15]}}, elem[15:0]} : {16'd0, elem[15:0]};
            default:         res = elem;
        endcase
        return res;
    endfunction

    // Only the signed min and max need sign extension
    assign is_signed     = operation_i inside {ipu_pkg::VMIN, ipu_pkg::VMAX};
    assign lane_signed_o = is_signed;

    ////////////////////////////////////////////////////////////
    // Handshake and lane activation
    ////////////////////////////////////////////////////////////

    assign operation_ready_o = lane_ready_i[ipu_pkg::WIDE_LANE];
    assign accept            = operation_valid_i & operation_ready_o;

    always_comb begin : active_lanes
        unique case (sew_i)
            ipu_pkg::SEW_8:  lane_active = 4'b1111;
            ipu_pkg::SEW_16: lane_active = 4'b1100;
            default:         lane_active = 4'b1000;
        endcase
    end

    assign lane_valid_o = {ipu_pkg::NUM_LANES{accept}} & lane_active;

    ////////////////////////////////////////////////////////////
    // Operand split
    ////////////////////////////////////////////////////////////

    always_comb begin : operand_split
        lane_op_a_o = '0;
        lane_op_b_o = '0;
        unique case (sew_i)
            ipu_pkg::SEW_8: begin
                // Byte k to lane k
                for (int i = 0; i < ipu_pkg::NUM_LANES; i++) begin
                    lane_op_a_o[i] = extend(op_s1_i >> (8 * i), ipu_pkg::SEW_8, is_signed);
                    lane_op_b_o[i] = extend(op_s2_i >> (8 * i), ipu_pkg::SEW_8, is_signed);
                end
            end
            ipu_pkg::SEW_16: begin
                // Halfwords 0 and 1 to lanes 2 and 3
                for (int k = 0; k < 2; k++) begin
                    lane_op_a_o[2 + k] = extend(op_s1_i >> (16 * k), ipu_pkg::SEW_16, is_signed);
                    lane_op_b_o[2 + k] = extend(op_s2_i >> (16 * k), ipu_pkg::SEW_16, is_signed);
                end
            end
            default: begin
                lane_op_a_o[ipu_pkg::WIDE_LANE] = op_s1_i;
                lane_op_b_o[ipu_pkg::WIDE_LANE] = op_s2_i;
            end
        endcase
    end

endmodule

//--- src/ipu_pkg.sv
////////////////////////////////////////////////////////////
// Shared widths, lane layout and encodings of the SIMD IPU
// Lane layout is fixed at 8, 8, 16 and 32 bits
// Only 32-bit words; no 64-bit elements
////////////////////////////////////////////////////////////

package ipu_pkg;

    ////////////////////////////////////////////////////////////
    // Widths
    ////////////////////////////////////////////////////////////

    localparam int unsigned WORD_W = 32;
    localparam int unsigned STRB_W = WORD_W / 8;

    ////////////////////////////////////////////////////////////
    // Lane layout
    ////////////////////////////////////////////////////////////

    localparam int unsigned NUM_LANES = 4;

    // Lane widths, index 0 first
    localparam int unsigned LANE_WIDTH [NUM_LANES] = '{8, 8, 16, 32};

    // Lane that is active for every element width
    localparam int unsigned WIDE_LANE = 3;

    ////////////////////////////////////////////////////////////
    // Types
    ////////////////////////////////////////////////////////////

    typedef logic [WORD_W-1:0] word_t;
    typedef logic [STRB_W-1:0] strb_t;

    typedef enum logic [1:0] {
        SEW_8  = 2'd0,
        SEW_16 = 2'd1,
        SEW_32 = 2'd2
    } sew_e;

    typedef enum logic [3:0] {
        VADD  = 4'h0,
        VSUB  = 4'h1,
        VRSUB = 4'h2,
        VAND  = 4'h3,
        VOR   = 4'h4,
        VXOR  = 4'h5,
        VMIN  = 4'h6,
        VMINU = 4'h7,
        VMAX  = 4'h8,
        VMAXU = 4'h9
    } op_e;

endpackage
